/* baud_timer.sv */
//####################
// Counter runs only while run is high
// Count is zero on the first cycle of run
// Strobes are combinational decodes of the count
//####################
`timescale 1ns/1ns
`default_nettype none

module baud_timer import uart_echo_pkg::*; (
	input  wire  iCE_CLK,
	input  wire  rst_n,
	input  logic run,     // High while a frame is in progress
	output logic bit_mid, // One cycle at the sample point
	output logic bit_end  // One cycle at the last clock of a bit
);

	logic [BIT_CNT_W-1:0] count; // Position inside the current bit
	logic                 at_end; // Count sits on the last clock of a bit

	assign at_end = (count == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// Bit period counter
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;                      // Clears as soon as run drops
		end else if (at_end) begin
			count <= '0;                      // Wrap into next bit
		end else begin
			count <= count + 1'b1;
		end
	end

	// Strobes only while the counter is live
	assign bit_mid = run && (count == BIT_CNT_W'(HALF_BIT - 1));
	assign bit_end = run && at_end;

	// Counter stays inside one bit period
	a_count_range: assert property (
		@(posedge iCE_CLK) disable iff (!rst_n)
		count < BIT_CNT_W'(CLKS_PER_BIT)
	);

endmodule

`default_nettype wire

/* compile.f */
uart_echo_pkg.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
echo_ctrl.sv
uart_echo_top.sv
tb_uart_echo.sv

/* echo_ctrl.sv */
//####################
// Holds a single byte, a newer one overwrites it
// tx_start only fires while tx_busy is low
// LED 4 latches a framing error until the next good byte
//####################
`timescale 1ns/1ns
`default_nettype none

module echo_ctrl import uart_echo_pkg::*; (
	input  wire        iCE_CLK,
	input  wire        rst_n,
	input  logic       rx_valid,     // Good byte strobe
	input  logic       rx_frame_err, // Bad frame strobe
	input  uart_byte_t rx_byte,      // Received data
	input  logic       tx_busy,      // Transmitter in use
	output logic       tx_start,     // Launch pulse
	output uart_byte_t tx_byte,      // Byte to echo
	output leds_t      leds          // Board LEDs
);

	echo_state_t state; // Echo FSM

	// Echo FSM
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			state    <= EC_IDLE;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;              // Single cycle pulse
			case (state)
				EC_IDLE, EC_PENDING: begin
					if (rx_valid || state == EC_PENDING) begin
						if (!tx_busy) begin
							tx_start <= 1'b1;    // Launch next cycle
							state    <= EC_LAUNCH;
						end else begin
							state <= EC_PENDING; // Wait for transmitter
						end
					end
				end
				EC_LAUNCH: begin
					// tx_busy rises next cycle, so a new byte must wait
					state <= rx_valid ? EC_PENDING : EC_IDLE;
				end
				default: state <= EC_IDLE;
			endcase
		end
	end

	// Held byte, newest wins
	always_ff @(posedge iCE_CLK) begin
		if (rx_valid) begin
			tx_byte <= rx_byte;
		end
	end

	// LED word
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			leds <= '0;
		end else if (rx_valid) begin
			leds[3:0] <= rx_byte[7:4];     // Upper nibble
			leds[4]   <= 1'b0;             // Good byte clears error
		end else if (rx_frame_err) begin
			leds[4] <= 1'b1;               // Nibble left as is
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the UART echo testbench with Verilator and runs it.
# Exits with status 0 only when the run reports success.

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
fail_msg="*** TEST FAILED ***"
pass_msg="*** TEST PASSED ***"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_uart_echo -f compile.f -o sim_uart_echo
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_uart_echo > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "$fail_msg" "$log_file"; then
	echo "Failure reported, see $log_file"
	exit 1
fi

if ! grep -qF "$pass_msg" "$log_file"; then
	echo "No result line found in $log_file"
	exit 1
fi

echo "Simulation passed"
exit 0

/* tb_uart_echo.sv */
//####################
// Drives 8N1 frames on rs232_rx and decodes rs232_tx at mid-bit
// Bit timing comes from CLKS_PER_BIT, one frame is 12500 clocks
// Outputs are sampled on the falling clock edge
//####################
`timescale 1ns/1ns
`default_nettype none

module tb_uart_echo import uart_echo_pkg::*; ();

	logic       iCE_CLK;
	logic       rst_n;
	logic       rs232_rx;
	logic       rs232_tx;
	leds_t      leds;

	integer     seed;           // $random state
	int         check_errors;   // Wrong values and bad frames
	int         timeout_errors; // Waits that ran out
	uart_byte_t exp_q[$];       // Model, bytes still to be echoed
	uart_byte_t got_q[$];       // Bytes decoded from rs232_tx
	leds_t      exp_leds;       // Model, LED word

	uart_echo_top DUT (
		.iCE_CLK  (iCE_CLK),
		.rst_n    (rst_n),
		.rs232_rx (rs232_rx),
		.rs232_tx (rs232_tx),
		.leds     (leds)
	);

	initial begin
		iCE_CLK = 1'b0;
		forever #2 iCE_CLK = ~iCE_CLK; // 4 ns period
	end

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s expected 8'h%02h actual 8'h%02h", name, exp, act);
		end
	endtask

	task automatic check_leds(input string name, input leds_t exp, input leds_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s expected 5'b%05b actual 5'b%05b", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	// Reference model, runs when a frame has been fully sent
	task automatic model_frame(input uart_byte_t data, input logic stop_bit);
		if (stop_bit) begin
			exp_q.push_back(data);            // Good byte comes back
			exp_leds = {1'b0, data[7:4]};     // Nibble shown, error cleared
		end else begin
			exp_leds[4] = 1'b1;               // Nibble kept
		end
	endtask

	task automatic sync_drive();
		@(posedge iCE_CLK);
		#1;                                 // Drive just after the edge
	endtask

	// Holds the line for a number of clocks, ends 1 ns after an edge
	task automatic hold_line(input logic level, input int cycles);
		rs232_rx = level;
		repeat (cycles) @(posedge iCE_CLK);
		#1;
	endtask

	task automatic send_frame(input uart_byte_t data, input logic stop_bit);
		uart_byte_t bits;
		bits = data;
		hold_line(1'b0, CLKS_PER_BIT);      // Start bit
		repeat (8) begin
			hold_line(bits[0], CLKS_PER_BIT); // LSB first
			bits = bits >> 1;
		end
		hold_line(stop_bit, CLKS_PER_BIT);  // Low here forces a framing error
		rs232_rx = 1'b1;
		model_frame(data, stop_bit);
	endtask

	// Called on the first low sample of a start bit
	task automatic decode_frame(output uart_byte_t data, output logic framed);
		uart_byte_t bits;
		bits = '0;
		repeat (HALF_BIT) @(negedge iCE_CLK);
		framed = (rs232_tx === 1'b0);       // Middle of start bit
		repeat (8) begin
			repeat (CLKS_PER_BIT) @(negedge iCE_CLK);
			bits = {rs232_tx, bits[7:1]};
		end
		repeat (CLKS_PER_BIT) @(negedge iCE_CLK);
		framed = framed && (rs232_tx === 1'b1); // Stop bit
		data = bits;
	endtask

	task automatic wait_echo(input string name);
		int waited;
		waited = 0;
		while (got_q.size() == 0 && waited < 3 * 10 * CLKS_PER_BIT) begin
			@(negedge iCE_CLK);
			waited++;
		end
		if (got_q.size() == 0) begin
			timeout_errors++;
			$display("Timeout in %s: no echo on rs232_tx within %0d cycles", name, waited);
		end else if (exp_q.size() == 0) begin
			check_errors++;
			$display("%s: echo 8'h%02h arrived with no byte pending", name, got_q.pop_front());
		end else begin
			check_byte(name, exp_q.pop_front(), got_q.pop_front());
		end
	endtask

	task automatic expect_silence(input string name, input int cycles);
		int active;
		active = 0;
		repeat (cycles) begin
			@(negedge iCE_CLK);
			if (rs232_tx !== 1'b1) begin
				active++;
			end
		end
		if (active != 0 || got_q.size() != 0) begin
			check_errors++;
			$display("%s: rs232_tx was active for %0d cycles with no echo due", name, active);
			got_q.delete();
		end
	endtask

	// Serial monitor on rs232_tx
	initial begin : monitor
		uart_byte_t data;
		logic       framed;
		int         idle;
		logic       running;
		running = 1'b1;
		idle = 0;
		while (rst_n !== 1'b1 && idle < 100) begin
			@(negedge iCE_CLK);
			idle++;
		end
		if (rst_n !== 1'b1) begin
			timeout_errors++;
			$display("Monitor never saw reset released");
			running = 1'b0;
		end
		while (running) begin
			idle = 0;
			while (rs232_tx !== 1'b0 && idle < 20 * 10 * CLKS_PER_BIT) begin
				@(negedge iCE_CLK);
				idle++;
			end
			if (rs232_tx !== 1'b0) begin
				timeout_errors++;
				$display("Monitor saw no start bit on rs232_tx for %0d cycles", idle);
				running = 1'b0;
			end else begin
				decode_frame(data, framed);
				if (!framed) begin
					check_errors++;
					$display("Monitor saw a bad start or stop bit on rs232_tx");
				end
				got_q.push_back(data);
			end
		end
	end

	initial begin : main
		uart_byte_t data;
		seed = 32'h3875;
		check_errors = 0;
		timeout_errors = 0;
		exp_leds = '0;
		rst_n = 1'b0;
		rs232_rx = 1'b1;                    // Idle line
		repeat (4) @(posedge iCE_CLK);
		#1;
		rst_n = 1'b1;

		repeat (200) begin                  // Quiet after reset
			@(negedge iCE_CLK);
			check_line("reset_tx_idle", 1'b1, rs232_tx);
			check_leds("reset_leds", exp_leds, leds);
		end

		sync_drive();
		fork
			begin
				repeat (12) begin
					send_frame(uart_byte_t'($random(seed)), 1'b1);
					hold_line(1'b1, CLKS_PER_BIT); // One idle bit
				end
			end
			begin
				repeat (12) begin
					wait_echo("echo");
					check_leds("echo_leds", exp_leds, leds);
				end
			end
		join

		sync_drive();
		data = uart_byte_t'($random(seed));
		send_frame(data, 1'b0);             // Low stop bit
		expect_silence("frame_err_no_echo", 2 * 10 * CLKS_PER_BIT);
		check_leds("frame_err_leds", exp_leds, leds);
		sync_drive();
		send_frame(uart_byte_t'($random(seed)), 1'b1);
		wait_echo("frame_err_recover");
		check_leds("frame_err_cleared", exp_leds, leds);

		sync_drive();
		hold_line(1'b0, CLKS_PER_BIT / 8);  // Well under a quarter bit
		rs232_rx = 1'b1;
		expect_silence("glitch_no_echo", 2 * 10 * CLKS_PER_BIT);
		check_leds("glitch_leds", exp_leds, leds);
		sync_drive();
		send_frame(uart_byte_t'($random(seed)), 1'b1);
		wait_echo("glitch_recover");
		check_leds("glitch_recover_leds", exp_leds, leds);

		sync_drive();
		fork
			begin
				repeat (8) begin
					send_frame(uart_byte_t'($random(seed)), 1'b1); // No gap
				end
			end
			begin
				repeat (8) begin
					wait_echo("back_to_back");
				end
			end
		join
		check_leds("back_to_back_leds", exp_leds, leds);
		if (exp_q.size() != 0 || got_q.size() != 0) begin
			check_errors++;
			$display("Echo count mismatch: %0d expected left, %0d received left",
				exp_q.size(), got_q.size());
		end

		$display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_echo_pkg.sv */
//####################
// Constants assume a 12 MHz iCE_CLK and a fixed 9600 baud line
// CLKS_PER_BIT must divide evenly enough that timing error stays small
// Frame format is fixed 8N1 with no parity
//####################
`default_nettype none

package uart_echo_pkg;

	// Clock and line rate
	localparam int CLK_FREQ_HZ  = 12_000_000;                 // iCE_CLK frequency
	localparam int BAUD_RATE    = 9600;                       // Serial line rate
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;    // 1250 cycles per bit
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;           // Sample point inside a bit
	localparam int BIT_CNT_W    = 11;                         // Holds 0 to CLKS_PER_BIT-1

	// One serial data byte
	typedef logic [7:0] uart_byte_t;

	// Bits 3:0 upper nibble of last good byte, bit 4 framing error flag
	typedef logic [4:0] leds_t;

	// Receiver states
	typedef enum logic [1:0] {
		RX_IDLE,  // Waiting for falling edge
		RX_START, // Checking start bit at mid-bit
		RX_DATA,  // Sampling eight data bits
		RX_STOP   // Checking stop bit
	} rx_state_t;

	// Transmitter states
	typedef enum logic [1:0] {
		TX_IDLE,  // Line held high
		TX_START, // Driving start bit
		TX_DATA,  // Shifting data LSB first
		TX_STOP   // Driving stop bit
	} tx_state_t;

	// Echo control states
	typedef enum logic [1:0] {
		EC_IDLE,    // Nothing held
		EC_PENDING, // Byte held, transmitter busy
		EC_LAUNCH   // Start pulse out this cycle
	} echo_state_t;

endpackage

`default_nettype wire

/* uart_echo_top.sv */
//####################
// iCE40 board at 12 MHz, 8N1 at 9600 baud
// rs232_rx is asynchronous to iCE_CLK
// rst_n is asynchronous, active low
// Only one echo byte is buffered
//####################
`timescale 1ns/1ns
`default_nettype none

module uart_echo_top import uart_echo_pkg::*; (
	input  wire   iCE_CLK,
	input  wire   rst_n,
	input  logic  rs232_rx, // Serial in from host
	output logic  rs232_tx, // Serial echo to host
	output leds_t leds      // Nibble and error LEDs
);

	logic       rx_run;       // Receiver timer enable
	logic       rx_bit_mid;   // Receiver sample strobe
	logic       tx_run;       // Transmitter timer enable
	logic       tx_bit_end;   // Transmitter bit boundary
	logic       rx_valid;     // Good frame
	logic       rx_frame_err; // Bad stop bit
	uart_byte_t rx_byte;      // Received data
	logic       tx_start;     // Echo launch
	uart_byte_t tx_byte;      // Echo data
	logic       tx_busy;      // Echo in progress

	baud_timer rx_timer (
		.iCE_CLK (iCE_CLK),
		.rst_n   (rst_n),
		.run     (rx_run),
		.bit_mid (rx_bit_mid),
		.bit_end ()               // Receiver stops at stop-bit middle
	);

	baud_timer tx_timer (
		.iCE_CLK (iCE_CLK),
		.rst_n   (rst_n),
		.run     (tx_run),
		.bit_mid (),              // Transmitter works on bit edges
		.bit_end (tx_bit_end)
	);

	uart_rx u_rx (
		.iCE_CLK      (iCE_CLK),
		.rst_n        (rst_n),
		.rx           (rs232_rx),
		.bit_mid      (rx_bit_mid),
		.run          (rx_run),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err),
		.rx_byte      (rx_byte)
	);

	echo_ctrl u_ctrl (
		.iCE_CLK      (iCE_CLK),
		.rst_n        (rst_n),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err),
		.rx_byte      (rx_byte),
		.tx_busy      (tx_busy),
		.tx_start     (tx_start),
		.tx_byte      (tx_byte),
		.leds         (leds)
	);

	uart_tx u_tx (
		.iCE_CLK  (iCE_CLK),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.bit_end  (tx_bit_end),
		.run      (tx_run),
		.tx       (rs232_tx),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

/* uart_rx.sv */
//####################
// rx is asynchronous and passes a two-flop synchronizer
// A start bit must still be low at mid-bit or it is dropped
// Frame result pulses one cycle after the stop-bit sample
// rx_byte holds until the next good frame
//####################
`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_echo_pkg::*; (
	input  wire        iCE_CLK,
	input  wire        rst_n,
	input  logic       rx,           // Serial line from the pin
	input  logic       bit_mid,      // Sample strobe from rx_timer
	output logic       run,          // Keeps rx_timer counting
	output logic       rx_valid,     // Good frame, one cycle
	output logic       rx_frame_err, // Low stop bit, one cycle
	output uart_byte_t rx_byte       // Last good byte
);

	rx_state_t  state;     // Receiver FSM
	logic       rx_meta;   // First synchronizer stage
	logic       rx_sync;   // Second synchronizer stage
	logic       rx_prev;   // For falling edge detect
	logic       rx_fall;   // Line went high to low
	logic [2:0] bit_idx;   // Data bit being sampled
	uart_byte_t shift_reg; // Data collected LSB first

	// Two-flop synchronizer plus edge history
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;               // Idle line is high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign rx_fall = rx_prev && !rx_sync;

	// Timer runs for the whole frame
	assign run = (state != RX_IDLE);

	// Receiver FSM
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			state        <= RX_IDLE;
			bit_idx      <= '0;
			rx_valid     <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_valid     <= 1'b0;          // Pulses by default
			rx_frame_err <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (rx_fall) begin
						state <= RX_START;     // Timer starts next cycle
					end
				end
				RX_START: begin
					if (bit_mid) begin
						if (!rx_sync) begin
							state   <= RX_DATA;  // Real start bit
							bit_idx <= '0;
						end else begin
							state <= RX_IDLE;    // Glitch, go back
						end
					end
				end
				RX_DATA: begin
					if (bit_mid) begin
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				RX_STOP: begin
					if (bit_mid) begin
						state        <= RX_IDLE; // Free for next start edge
						rx_valid     <= rx_sync;
						rx_frame_err <= !rx_sync;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data path
	always_ff @(posedge iCE_CLK) begin
		if (state == RX_DATA && bit_mid) begin
			shift_reg <= {rx_sync, shift_reg[7:1]}; // LSB arrives first
		end
		if (state == RX_STOP && bit_mid && rx_sync) begin
			rx_byte <= shift_reg;              // Only good frames update
		end
	end

	// A frame ends as good or bad, never both
	a_one_result: assert property (
		@(posedge iCE_CLK) disable iff (!rst_n)
		!(rx_valid && rx_frame_err)
	);

endmodule

`default_nettype wire

/* uart_tx.sv */
//####################
// tx_start is taken only in TX_IDLE
// Line goes low the cycle after tx_start
// tx_busy covers start bit through end of stop bit
//####################
`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_echo_pkg::*; (
	input  wire        iCE_CLK,
	input  wire        rst_n,
	input  logic       tx_start, // Launch pulse
	input  uart_byte_t tx_byte,  // Sampled with tx_start
	input  logic       bit_end,  // Bit boundary from tx_timer
	output logic       run,      // Keeps tx_timer counting
	output logic       tx,       // Registered serial line
	output logic       tx_busy   // Frame in progress
);

	tx_state_t  state;     // Transmitter FSM
	logic [2:0] bit_idx;   // Data bit on the line
	uart_byte_t shift_reg; // Remaining data bits

	assign tx_busy = (state != TX_IDLE);
	assign run     = tx_busy;          // Timer spans the whole frame

	// Transmitter FSM and line register
	always_ff @(posedge iCE_CLK or negedge rst_n) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			bit_idx <= '0;
			tx      <= 1'b1;               // Idle high
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						state <= TX_START;
						tx    <= 1'b0;         // Start bit
					end
				end
				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						bit_idx <= '0;
						tx      <= shift_reg[0]; // Bit 0
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
							tx    <= 1'b1;       // Stop bit
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx      <= shift_reg[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;      // Line already high
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Shift register
	always_ff @(posedge iCE_CLK) begin
		if (state == TX_IDLE && tx_start) begin
			shift_reg <= tx_byte;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift_reg <= {1'b0, shift_reg[7:1]}; // Next bit into [0]
		end
	end

	// Idle line is always high
	a_idle_high: assert property (
		@(posedge iCE_CLK) disable iff (!rst_n)
		(state == TX_IDLE) |-> tx
	);

	// Controller must wait for idle
	a_no_start_busy: assert property (
		@(posedge iCE_CLK) disable iff (!rst_n)
		tx_start |-> !tx_busy
	);

endmodule

`default_nettype wire
